/* compile.f */
verilog/disk_geometry_pkg.sv
verilog/loader_ctrl_pkg.sv
verilog/sd_xfer_if.sv
verilog/track_loader_fsm.sv
verilog/sector_counter.sv
verilog/track_buffer.sv
verilog/reset_stretcher.sv
verilog/track_loader_top.sv
tb/track_loader_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the track loader testbench under Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module track_loader_tb -f compile.f -o track_loader_sim
# The simulator exits non-zero on a fatal stop, the log holds the result
./obj_dir/track_loader_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
grep -q "RESULT: PASS" sim.log

/* tb/track_loader_tb.sv */
// Testbench for the floppy track loader with HOLD_BITS of 6.
// A host model answers every request with 13 blocks of 512 bytes.
// Buffer reads are checked only inside one loaded track (below 6656).

`timescale 1ns/1ps

module track_loader_tb;

	localparam int HOLD_BITS = 6;
	localparam int HOLD_EDGES = 2 ** (HOLD_BITS - 1) + 1;
	// Mount, clean track change, write-back plus read
	localparam int WATCHDOG_CYCLES = (13 + 13 + 26) * 600 + 2000;

	logic        CLK_VIDEO;
	logic        dd_reset, img_mounted_i, sd_ack_i, sd_buff_wr_i, fd_write_i, rst_req_i;
	logic [5:0]  track_i;
	logic [63:0] img_size_i;
	logic [8:0]  sd_buff_addr_i;
	logic [7:0]  sd_buff_dout_i, sd_buff_din_o, fd_data_i, fd_data_o;
	logic        sd_rd_o, sd_wr_o, cpu_wait_o, sys_reset_o;
	logic [31:0] sd_lba_o;
	logic [12:0] fd_addr_i;

	logic [15:0] lfsr_state = 16'd95;
	logic [5:0]  loaded_track = '0;
	logic [63:0] mounted_size = '0;
	logic        expect_wb = 1'b0, read_check_on = 1'b0;
	logic [3:0]  host_blk = '0;
	logic [31:0] host_lba = '0;
	logic        host_write = 1'b0, final_read = 1'b0;
	logic [12:0] wr_addr [6];
	logic [7:0]  wr_data [6];
	int          wr_count = 0;
	// What the DUT sampled at the last rising edge
	logic [12:0] fd_addr_q, host_addr_q;
	logic        read_q = 1'b0, wb_q = 1'b0;
	int          quiet_edges = 0;

	track_loader_top #(.HOLD_BITS(HOLD_BITS)) dut_i (.*);

	initial begin
		CLK_VIDEO = 1'b0;
		forever #50 CLK_VIDEO = ~CLK_VIDEO;
	end

	// ============================================================
	// Failure reporting and random numbers
	// ============================================================
	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("Error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
		stop_run();
	endtask

	task automatic report_failure(input string what);
		$display("Error at time %0t: %s", $time, what);
		stop_run();
	endtask

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	// Host image content for one block address and byte offset
	function automatic logic [7:0] host_byte(input logic [31:0] lba, input logic [8:0] offset);
		logic [31:0] mix;
		mix = lba * 29 + (lba >> 8) + offset * 7 + (offset >> 8);
		return mix[7:0];
	endfunction

	function automatic logic [7:0] expected_read(input logic [12:0] a);
		return host_byte(13 * loaded_track + a[12:9], a[8:0]);
	endfunction

	// Last drive write to an address, or -1
	function automatic int written_slot(input logic [12:0] a);
		int slot;
		slot = -1;
		for (int i = 0; i < wr_count; i++)
			if (wr_addr[i] == a)
				slot = i;
		return slot;
	endfunction

	always @(posedge CLK_VIDEO) begin
		fd_addr_q <= fd_addr_i;
		host_addr_q <= {host_blk, sd_buff_addr_i};
		read_q <= read_check_on;
		wb_q <= host_write && sd_ack_i;
		if (dd_reset || rst_req_i)
			quiet_edges <= 0;
		else if (quiet_edges < HOLD_EDGES)
			quiet_edges <= quiet_edges + 1;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge CLK_VIDEO);
		$display("Timeout: transfers did not finish within %0d cycles", WATCHDOG_CYCLES);
		stop_run();
	end

	// ============================================================
	// SD host model
	// ============================================================
	task automatic serve_request();
		logic        is_write;
		logic [31:0] base;
		logic [31:0] gap;
		is_write = sd_wr_o;
		base = 13 * (is_write ? loaded_track : track_i);
		host_write = is_write;
		for (int b = 0; b < 13; b++) begin
			draw_bits(3, gap);
			repeat (gap + 1) @(posedge CLK_VIDEO);
			#10;
			host_blk = 4'(b);
			host_lba = base + 32'(b);
			final_read = !is_write && (b == 12);
			sd_ack_i = 1'b1;
			for (int i = 0; i < 512; i++) begin
				sd_buff_addr_i = 9'(i);
				sd_buff_wr_i = !is_write;
				sd_buff_dout_i = host_byte(host_lba, 9'(i));
				@(posedge CLK_VIDEO);
				#10;
			end
			sd_ack_i = 1'b0;
			sd_buff_wr_i = 1'b0;
		end
	endtask

	initial begin : host_model
		forever begin
			@(negedge CLK_VIDEO);
			if (sd_rd_o || sd_wr_o)
				serve_request();
		end
	end

	// ============================================================
	// Checks, sampled at the falling edge
	// ============================================================
	a_reset_values: assert property (@(negedge CLK_VIDEO)
		dd_reset |-> (!sd_rd_o && !sd_wr_o && !cpu_wait_o && sys_reset_o))
		else report_mismatch("{sd_rd_o,sd_wr_o,cpu_wait_o,sys_reset_o}",
			{sd_rd_o, sd_wr_o, cpu_wait_o, sys_reset_o}, 4'b0001);
	a_stretch: assert property (@(negedge CLK_VIDEO)
		sys_reset_o == (quiet_edges < HOLD_EDGES))
		else report_mismatch("sys_reset_o", sys_reset_o, quiet_edges < HOLD_EDGES);
	a_req_excl: assert property (@(negedge CLK_VIDEO) disable iff (dd_reset)
		!(sd_rd_o && sd_wr_o))
		else report_failure("sd_rd_o and sd_wr_o are high together");
	a_empty_image: assert property (@(negedge CLK_VIDEO) disable iff (dd_reset)
		$rose(sd_rd_o || sd_wr_o) |-> (mounted_size != 0))
		else report_failure("a request was raised while the image size is zero");
	a_start_kind: assert property (@(negedge CLK_VIDEO) disable iff (dd_reset)
		$rose(cpu_wait_o) |=> (sd_wr_o == expect_wb && sd_rd_o == !expect_wb))
		else report_mismatch("{sd_wr_o,sd_rd_o}", {sd_wr_o, sd_rd_o}, {expect_wb, !expect_wb});
	a_block_lba: assert property (@(negedge CLK_VIDEO) disable iff (dd_reset)
		$rose(sd_ack_i) |-> (sd_lba_o == host_lba))
		else report_mismatch("sd_lba_o", sd_lba_o, host_lba);
	a_req_drop: assert property (@(negedge CLK_VIDEO) disable iff (dd_reset)
		$rose(sd_ack_i) |=> ((sd_rd_o || sd_wr_o) == (host_blk != 4'd12)))
		else report_mismatch("sd_rd_o|sd_wr_o", sd_rd_o || sd_wr_o, host_blk != 4'd12);
	a_wait_end: assert property (@(negedge CLK_VIDEO) disable iff (dd_reset)
		$fell(sd_ack_i) && final_read |=> !cpu_wait_o)
		else report_mismatch("cpu_wait_o", cpu_wait_o, 1'b0);
	a_wait_held: assert property (@(negedge CLK_VIDEO) disable iff (dd_reset)
		$fell(sd_ack_i) && !final_read |=> cpu_wait_o)
		else report_mismatch("cpu_wait_o", cpu_wait_o, 1'b1);
	a_fd_read: assert property (@(negedge CLK_VIDEO) disable iff (dd_reset)
		read_q |-> (fd_data_o == expected_read(fd_addr_q)))
		else report_mismatch("fd_data_o", fd_data_o, expected_read(fd_addr_q));
	a_wb_data: assert property (@(negedge CLK_VIDEO) disable iff (dd_reset)
		wb_q && (written_slot(host_addr_q) >= 0) |->
			(sd_buff_din_o == wr_data[written_slot(host_addr_q)]))
		else report_mismatch("sd_buff_din_o", sd_buff_din_o, wr_data[written_slot(host_addr_q)]);

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic next_cycle();
		@(posedge CLK_VIDEO);
		#10;
	endtask

	task automatic wait_transfer();
		while (!cpu_wait_o)
			next_cycle();
		while (cpu_wait_o)
			next_cycle();
	endtask

	task automatic check_random_reads(input int n);
		logic [31:0] value;
		for (int k = 0; k < n; k++) begin
			draw_bits(13, value);
			fd_addr_i = 13'(value % 6656);
			read_check_on = 1'b1;
			next_cycle();
		end
		read_check_on = 1'b0;
		next_cycle();
	endtask

	task automatic write_random_bytes(input int n);
		logic [31:0] value;
		for (int k = 0; k < n; k++) begin
			draw_bits(13, value);
			fd_addr_i = 13'(value % 6656);
			draw_bits(8, value);
			fd_data_i = value[7:0];
			fd_write_i = 1'b1;
			wr_addr[wr_count] = fd_addr_i;
			wr_data[wr_count] = fd_data_i;
			wr_count++;
			next_cycle();
		end
		fd_write_i = 1'b0;
	endtask

	initial begin : stimulus
		dd_reset = 1'b1;
		track_i = '0;
		img_mounted_i = 1'b0;
		img_size_i = '0;
		sd_ack_i = 1'b0;
		sd_buff_addr_i = '0;
		sd_buff_wr_i = 1'b0;
		sd_buff_dout_i = '0;
		fd_addr_i = '0;
		fd_write_i = 1'b0;
		fd_data_i = '0;
		rst_req_i = 1'b0;
		repeat (16) @(posedge CLK_VIDEO);
		#10;
		dd_reset = 1'b0;

		// Reset hold, then a second request
		repeat (HOLD_EDGES + 4) next_cycle();
		rst_req_i = 1'b1;
		repeat (3) next_cycle();
		rst_req_i = 1'b0;
		repeat (HOLD_EDGES + 4) next_cycle();

		// Track change before any image is mounted
		track_i = 6'd3;
		repeat (10) next_cycle();

		img_size_i = 64'd425984;
		mounted_size = img_size_i;
		img_mounted_i = 1'b1;
		next_cycle();
		img_mounted_i = 1'b0;
		wait_transfer();
		loaded_track = track_i;
		check_random_reads(40);

		// Clean track, read only
		track_i = 6'd7;
		wait_transfer();
		loaded_track = track_i;
		check_random_reads(40);

		// Dirty track, write-back first
		write_random_bytes(6);
		expect_wb = 1'b1;
		track_i = 6'd12;
		wait_transfer();
		loaded_track = track_i;
		expect_wb = 1'b0;
		check_random_reads(40);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* verilog/track_loader_top.sv */
// Floppy track loader with reset stretcher.
// Single drive, single SD slot, all logic on CLK_VIDEO.
// HOLD_BITS sets the reset hold time to 2^(HOLD_BITS-1) cycles.

`timescale 1ns/1ps

module track_loader_top import disk_geometry_pkg::*; import loader_ctrl_pkg::*; #(
	parameter int HOLD_BITS = 23
) (
	input  logic                     CLK_VIDEO,
	input  logic                     dd_reset,
	input  logic [TRACK_BITS-1:0]    track_i,
	input  logic                     img_mounted_i,
	input  logic [63:0]              img_size_i,
	input  logic                     sd_ack_i,
	input  logic [OFFSET_BITS-1:0]   sd_buff_addr_i,
	input  logic                     sd_buff_wr_i,
	input  logic [7:0]               sd_buff_dout_i,
	output logic [7:0]               sd_buff_din_o,
	output logic                     sd_rd_o,
	output logic                     sd_wr_o,
	output logic [LBA_BITS-1:0]      sd_lba_o,
	input  logic [BUF_ADDR_BITS-1:0] fd_addr_i,
	input  logic                     fd_write_i,
	input  logic [7:0]               fd_data_i,
	output logic [7:0]               fd_data_o,
	output logic                     cpu_wait_o,
	input  logic                     rst_req_i,
	output logic                     sys_reset_o
);

	logic                   load;
	logic [TRACK_BITS-1:0]  load_track;
	logic                   ack_rise;
	logic                   ack_fall;
	logic [SECTOR_BITS-1:0] sector;
	logic                   last_sector;

	// SD host byte stream
	sd_xfer_if sd_bus ();

	assign sd_bus.sd_ack = sd_ack_i;
	assign sd_bus.sd_buff_addr = sd_buff_addr_i;
	assign sd_bus.sd_buff_wr = sd_buff_wr_i;
	assign sd_bus.sd_buff_dout = sd_buff_dout_i;
	assign sd_buff_din_o = sd_bus.sd_buff_din;

	track_loader_fsm fsm_i (
		.CLK_VIDEO(CLK_VIDEO), .dd_reset(dd_reset), .track_i(track_i),
		.img_mounted_i(img_mounted_i), .img_size_i(img_size_i), .fd_write_i(fd_write_i),
		.sd(sd_bus.ctrl_side), .last_sector_i(last_sector), .load_o(load),
		.load_track_o(load_track), .ack_rise_o(ack_rise), .ack_fall_o(ack_fall),
		.sd_rd_o(sd_rd_o), .sd_wr_o(sd_wr_o), .cpu_wait_o(cpu_wait_o)
	);

	sector_counter counter_i (
		.CLK_VIDEO(CLK_VIDEO), .dd_reset(dd_reset), .load_i(load),
		.load_track_i(load_track), .ack_rise_i(ack_rise), .ack_fall_i(ack_fall),
		.sector_o(sector), .last_sector_o(last_sector), .sd_lba_o(sd_lba_o)
	);

	track_buffer buffer_i (
		.CLK_VIDEO(CLK_VIDEO), .sd(sd_bus.buf_side), .sector_i(sector),
		.fd_addr_i(fd_addr_i), .fd_write_i(fd_write_i), .fd_data_i(fd_data_i),
		.fd_data_o(fd_data_o)
	);

	reset_stretcher #(.HOLD_BITS(HOLD_BITS)) stretcher_i (
		.CLK_VIDEO(CLK_VIDEO), .dd_reset(dd_reset), .rst_req_i(rst_req_i),
		.sys_reset_o(sys_reset_o)
	);

endmodule

/* verilog/reset_stretcher.sv */
// Holds the system reset for 2^(HOLD_BITS-1) cycles after the last request.
// Counter stops once its top bit is set.

`timescale 1ns/1ps

module reset_stretcher #(
	parameter int HOLD_BITS = 23
) (
	input  logic CLK_VIDEO,
	input  logic dd_reset,
	input  logic rst_req_i,
	output logic sys_reset_o
);

	logic [HOLD_BITS-1:0] hold_cnt;

	always_ff @(posedge CLK_VIDEO) begin
		if (dd_reset || rst_req_i) begin
			// Restart the hold time
			hold_cnt <= '0;
			sys_reset_o <= 1'b1;
		end else if (hold_cnt[HOLD_BITS-1]) begin
			sys_reset_o <= 1'b0;
		end else begin
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

endmodule

/* verilog/track_buffer.sv */
// Dual-port track memory, 8 KB, one byte wide.
// SD port writes only while the host acknowledges a block.
// Both ports read registered; a read of a location written at the
// same edge returns the old byte.

`timescale 1ns/1ps

module track_buffer import disk_geometry_pkg::*; (
	input  logic                     CLK_VIDEO,
	sd_xfer_if.buf_side              sd,
	input  logic [SECTOR_BITS-1:0]   sector_i,
	input  logic [BUF_ADDR_BITS-1:0] fd_addr_i,
	input  logic                     fd_write_i,
	input  logic [7:0]               fd_data_i,
	output logic [7:0]               fd_data_o
);

	logic [7:0] mem [2**BUF_ADDR_BITS];
	buf_addr_t  sd_addr;
	buf_addr_t  fd_addr;
	logic       sd_we;

	// ============================================================
	// Address build
	// ============================================================
	// Host side composes sector and byte offset
	assign sd_addr.split = {sector_i, sd.sd_buff_addr};
	assign fd_addr.flat = fd_addr_i;
	assign sd_we = sd.sd_buff_wr && sd.sd_ack;

	// ============================================================
	// Memory
	// ============================================================
	always_ff @(posedge CLK_VIDEO) begin
		if (sd_we)
			mem[sd_addr.flat] <= sd.sd_buff_dout;
		if (fd_write_i)
			mem[fd_addr.flat] <= fd_data_i;
		sd.sd_buff_din <= mem[sd_addr.flat];
		fd_data_o <= mem[fd_addr.flat];
	end

	// Drive is stalled during transfers, so the ports never fight
	a_no_collision: assert property (@(posedge CLK_VIDEO)
		!(sd_we && fd_write_i && (sd_addr.flat == fd_addr.flat)));

endmodule

/* verilog/sector_counter.sv */
// Sector index and block address for one track transfer.
// The block address moves on each ack rise, the index on each ack fall.
// The index reaches 13 after the last block and waits for the next load.

`timescale 1ns/1ps

module sector_counter import disk_geometry_pkg::*; import loader_ctrl_pkg::*; (
	input  logic                   CLK_VIDEO,
	input  logic                   dd_reset,
	input  logic                   load_i,
	input  logic [TRACK_BITS-1:0]  load_track_i,
	input  logic                   ack_rise_i,
	input  logic                   ack_fall_i,
	output logic [SECTOR_BITS-1:0] sector_o,
	output logic                   last_sector_o,
	output logic [LBA_BITS-1:0]    sd_lba_o
);

	always_ff @(posedge CLK_VIDEO) begin
		if (dd_reset) begin
			sector_o <= '0;
			sd_lba_o <= '0;
		end else if (load_i) begin
			sector_o <= '0;
			// First block of the track
			sd_lba_o <= LBA_BITS'(SECTORS_PER_TRACK) * LBA_BITS'(load_track_i);
		end else begin
			if (ack_rise_i)
				sd_lba_o <= sd_lba_o + 1'b1;
			if (ack_fall_i)
				sector_o <= sector_o + 1'b1;
		end
	end

	assign last_sector_o = (sector_o >= SECTORS_PER_TRACK - 4'd1);

	// Host never starts a 14th block within one request
	a_sector_range: assert property (@(posedge CLK_VIDEO) disable iff (dd_reset)
		ack_rise_i |-> (sector_o <= SECTORS_PER_TRACK - 4'd1));

endmodule

/* verilog/track_loader_fsm.sv */
// Track loader control: write-back of a dirty track, then read of the new one.
// Requests are levels held until the ack rise of the last sector.
// A zero image size blocks every transfer.
// The dirty flag is set by any drive-side write and is not address aware.

`timescale 1ns/1ps

module track_loader_fsm import disk_geometry_pkg::*; import loader_ctrl_pkg::*; (
	input  logic                  CLK_VIDEO,
	input  logic                  dd_reset,
	input  logic [TRACK_BITS-1:0] track_i,
	input  logic                  img_mounted_i,
	input  logic [63:0]           img_size_i,
	input  logic                  fd_write_i,
	sd_xfer_if.ctrl_side          sd,
	input  logic                  last_sector_i,
	output logic                  load_o,
	output logic [TRACK_BITS-1:0] load_track_o,
	output logic                  ack_rise_o,
	output logic                  ack_fall_o,
	output logic                  sd_rd_o,
	output logic                  sd_wr_o,
	output logic                  cpu_wait_o
);

	loader_state_t         state;
	logic [63:0]           disk_size;
	logic [TRACK_BITS-1:0] cur_track;
	logic                  mounted;
	logic                  dirty;
	logic                  old_ack;
	logic                  busy;
	logic                  trigger;
	logic                  start;

	// ============================================================
	// Trigger and handshake decode
	// ============================================================
	assign trigger = (state == IDLE) &&
		((cur_track != track_i) || (mounted && !img_mounted_i));
	assign start = trigger && (disk_size != '0);
	assign busy = (state == WRITE_BACK) || (state == READ);

	// Edges only count while a block transfer is running
	assign ack_rise_o = busy && !old_ack && sd.sd_ack;
	assign ack_fall_o = busy && old_ack && !sd.sd_ack;

	// Old track for write-back, new track on the read start
	assign load_o = (start && dirty) || (state == START_READ);
	assign load_track_o = (state == START_READ) ? track_i : cur_track;

	always_ff @(posedge CLK_VIDEO) begin
		if (dd_reset) begin
			state <= IDLE;
			disk_size <= '0;
			cur_track <= '0;
			mounted <= 1'b0;
			dirty <= 1'b0;
			old_ack <= 1'b0;
			sd_rd_o <= 1'b0;
			sd_wr_o <= 1'b0;
			cpu_wait_o <= 1'b0;
		end else begin
			old_ack <= sd.sd_ack;
			if (img_mounted_i) begin
				disk_size <= img_size_i;
				mounted <= 1'b1;
			end else if (trigger) begin
				mounted <= 1'b0;
			end
			if (fd_write_i) begin
				dirty <= 1'b1;
			end else if (start) begin
				dirty <= 1'b0;
			end

			case (state)
				IDLE: begin
					if (start) begin
						cpu_wait_o <= 1'b1;
						if (dirty) begin
							sd_wr_o <= 1'b1;
							state <= WRITE_BACK;
						end else begin
							state <= START_READ;
						end
					end
				end
				WRITE_BACK: begin
					if (ack_rise_o && last_sector_i)
						sd_wr_o <= 1'b0;
					if (ack_fall_o && !sd_wr_o)
						state <= START_READ;
				end
				START_READ: begin
					cur_track <= track_i;
					sd_rd_o <= 1'b1;
					state <= READ;
				end
				READ: begin
					if (ack_rise_o && last_sector_i)
						sd_rd_o <= 1'b0;
					// Final block done, release the drive
					if (ack_fall_o && !sd_rd_o) begin
						cpu_wait_o <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_rd_wr_excl: assert property (@(posedge CLK_VIDEO) disable iff (dd_reset)
		!(sd_rd_o && sd_wr_o));

endmodule

/* verilog/sd_xfer_if.sv */
// SD host byte stream for one block transfer.
// The host owns ack, address, write strobe and write data.
// Only the buffer drives the read data back.

`timescale 1ns/1ps

interface sd_xfer_if;

	// Host acknowledge, high for the length of one block
	logic       sd_ack;
	// Byte offset within the current 512 byte block
	logic [8:0] sd_buff_addr;
	logic       sd_buff_wr;
	// Host to buffer data
	logic [7:0] sd_buff_dout;
	// Buffer to host data
	logic [7:0] sd_buff_din;

	modport buf_side (
		input  sd_ack,
		input  sd_buff_addr,
		input  sd_buff_wr,
		input  sd_buff_dout,
		output sd_buff_din
	);

	modport ctrl_side (input sd_ack);

endinterface

/* verilog/loader_ctrl_pkg.sv */
// Control definitions for the track loader.
// State codes follow the disk path encoding: idle, write back,
// start read, read.

package loader_ctrl_pkg;

	// ============================================================
	// Loader states
	// ============================================================
	typedef enum logic [1:0] {
		IDLE       = 2'b00,
		// Dirty track going back to the host
		WRITE_BACK = 2'b01,
		// One cycle to load the new track
		START_READ = 2'b10,
		READ       = 2'b11
	} loader_state_t;

	// SD block address width
	localparam int LBA_BITS = 32;

endpackage

/* verilog/disk_geometry_pkg.sv */
// Floppy disk geometry shared by the track loader blocks.
// A track is 13 sectors of 512 bytes, so one track fills 13 of the
// 16 sector slots of an 8 KB buffer.
// Track numbers are 6 bits wide (0 to 63).

package disk_geometry_pkg;

	// ============================================================
	// Geometry
	// ============================================================
	localparam logic [3:0] SECTORS_PER_TRACK = 4'd13;
	localparam int SECTOR_BYTES = 512;
	localparam int TRACK_BITS = 6;
	localparam int BUF_ADDR_BITS = 13;

	// Byte offset and sector index fields of a buffer address
	localparam int OFFSET_BITS = $clog2(SECTOR_BYTES);
	localparam int SECTOR_BITS = BUF_ADDR_BITS - OFFSET_BITS;

	// ============================================================
	// Track buffer address
	// ============================================================
	// Drive side sees a flat byte address, SD side a sector/offset pair
	typedef union packed {
		logic [BUF_ADDR_BITS-1:0] flat;
		struct packed {
			logic [SECTOR_BITS-1:0] sector;
			logic [OFFSET_BITS-1:0] offset;
		} split;
	} buf_addr_t;

endpackage
